//--- include/can_defs.svh
`ifndef CAN_DEFS_SVH
`define CAN_DEFS_SVH

//======================================================================
// CAN 2.0 field lengths, in bits
//======================================================================

localparam int LEN_ID_A = 11;  // Base identifier
localparam int LEN_ID_B = 18;  // Identifier extension
localparam int LEN_DLC = 4;
localparam int LEN_CRC = 15;
localparam int LEN_EOF = 7;    // All recessive

// Two bits only, the third one may already be the next SOF
localparam int LEN_INTERMISSION = 2;

// Error flag may be stretched by other nodes up to 12 dominant bits
localparam int LEN_FLAGS_MIN = 6;
localparam int LEN_FLAGS_MAX = 12;
localparam int LEN_DELIMITER = 8;

//======================================================================
// Protocol constants
//======================================================================

localparam int MAX_DLC = 8;  // Codes 9..15 still mean 8 bytes
localparam logic [LEN_CRC-1:0] CRC_POLY = 15'h4599;  // x15+x14+x10+x8+x7+x4+x3+1
localparam int STUFF_RUN = 5;  // Equal bits before a stuff bit

`endif

//--- hw/can_pkg.sv
`default_nettype none

package can_pkg;

	`include "can_defs.svh"

	// Field that the current destuffed bit belongs to
	typedef enum logic [3:0] {
		field_none,
		field_id_a,
		field_rtr_srr,     // RTR in base frame, SRR in extended frame
		field_ide,
		field_id_b,
		field_rtr,         // Extended frame only
		field_reserved1,   // Extended frame only
		field_reserved0,
		field_dlc,
		field_data,
		field_crc
	} can_field_e;

	// Error kinds, one per detected condition
	typedef enum logic [2:0] {
		error_none,
		error_stuff,
		error_crc_delimiter,
		error_ack_slot,
		error_ack_delimiter,
		error_eof,
		error_crc_mismatch,
		error_flag_length
	} can_error_e;

	// One destuffed bit on its way to the field registers
	typedef struct packed {
		logic strobe;
		can_field_e field;
		logic bit_value;
	} can_capture_t;

	// Decoded frame fields
	typedef struct packed {
		logic ide;
		logic rtr;
		logic srr;
		logic reserved1;
		logic reserved0;
		logic [LEN_ID_A-1:0] id_a;
		logic [LEN_ID_B-1:0] id_b;
		logic [LEN_DLC-1:0] dlc;
		logic [8*MAX_DLC-1:0] data;   // Bytes right-aligned
		logic [LEN_CRC-1:0] crc;      // As received
	} can_frame_t;

endpackage

`default_nettype wire

//--- hw/can_bit_stuff.sv
`timescale 1ns/10ps
`default_nettype none

module can_bit_stuff
	import can_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire rx_bit,
	input wire sample_point,
	input wire stuff_active,     // Stuffed part of the frame
	output logic stuff_bit,      // Current bit is a stuff bit, drop it
	output logic stuff_error     // Sixth equal bit in a row
);

	// Alternating preset so that no run exists right after reset
	localparam logic [STUFF_RUN-1:0] HISTORY_PRESET = STUFF_RUN'(32'h5555_5555);

	logic [STUFF_RUN-1:0] history;  // Last sampled bits, newest at bit 0
	logic run_dominant;
	logic run_recessive;
	logic check;

	assign run_dominant = (history == '0);
	assign run_recessive = &history;
	assign check = sample_point & stuff_active;

	// Opposite bit after a run is inserted by the transmitter
	assign stuff_bit = check & ((run_dominant & rx_bit) | (run_recessive & ~rx_bit));

	// Same level again means the transmitter broke the rule
	assign stuff_error = check & ((run_dominant & ~rx_bit) | (run_recessive & rx_bit));

	// Stuff bits themselves start the next run, so every sample is kept
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			history <= HISTORY_PRESET;
		else if (sample_point)
			history <= {history[STUFF_RUN-2:0], rx_bit};
	end

endmodule

`default_nettype wire

//--- hw/can_crc15.sv
`timescale 1ns/10ps
`default_nettype none

module can_crc15
	import can_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire crc_clear,      // Start of frame
	input wire crc_shift,      // One destuffed covered bit
	input wire rx_bit,
	output logic [LEN_CRC-1:0] crc_value
);

	logic feedback;

	// Incoming bit against the top of the register
	assign feedback = rx_bit ^ crc_value[LEN_CRC-1];

	//======================================================================
	// CRC-15 LFSR
	//======================================================================

	// SOF is dominant and would leave a cleared register at zero anyway
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_value <= '0;
		else if (crc_clear)
			crc_value <= '0;
		else if (crc_shift)
			crc_value <= {crc_value[LEN_CRC-2:0], 1'b0} ^ (feedback ? CRC_POLY : '0);
	end

endmodule

`default_nettype wire

//--- hw/can_frame_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module can_frame_sequencer
	import can_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire rx_bit,
	input wire sample_point,
	input wire stuff_bit,
	input wire stuff_error,
	input wire [LEN_CRC-1:0] crc_value,   // Computed over the received bits
	input wire can_frame_t frame,         // Fields decoded so far
	output logic stuff_active,
	output logic crc_shift,
	output logic crc_clear,
	output can_capture_t capture,
	output logic frame_done,
	output logic error_detected,
	output can_error_e error_kind
);

	// One-hot state positions, stuffed fields kept contiguous
	typedef enum int unsigned {
		s_idle,
		s_id_a,
		s_rtr_srr,
		s_ide,
		s_id_b,
		s_rtr,
		s_reserved1,
		s_reserved0,
		s_dlc,
		s_data,
		s_crc,
		s_crc_delimiter,
		s_ack_slot,
		s_ack_delimiter,
		s_eof,
		s_intermission,
		s_error_flags,
		s_error_delimiter,
		s_count
	} state_index_e;

	function automatic logic [s_count-1:0] onehot(input state_index_e index);
		logic [s_count-1:0] vec;
		vec = '0;
		vec[index] = 1'b1;
		return vec;
	endfunction

	logic [s_count-1:0] state;
	logic [s_count-1:0] state_next;
	logic [6:0] bit_count;     // Bits taken in the current field
	logic [6:0] data_len;      // 8 x DLC
	logic bit_ok;              // Sampled and not a stuff bit
	logic sof;
	logic done;
	can_error_e kind;
	can_field_e field_sel;

	assign bit_ok = sample_point & ~stuff_bit;
	assign sof = sample_point & ~rx_bit & (state[s_idle] | state[s_intermission]);
	assign data_len = {frame.dlc, 3'b000};  // DLC already clamped

	// CRC delimiter included since a CRC ending in a run is still stuffed
	assign stuff_active = |state[s_crc_delimiter:s_id_a];
	assign crc_shift = bit_ok & (|state[s_data:s_id_a]);
	assign crc_clear = sof;

	assign capture.strobe = bit_ok & (field_sel != field_none);
	assign capture.field = field_sel;
	assign capture.bit_value = rx_bit;

	//======================================================================
	// Next state and error detection
	//======================================================================

	always_comb
	begin
		state_next = state;
		kind = error_none;
		field_sel = field_none;
		done = 1'b0;
		unique case (1'b1)
			state[s_idle]:
				if (sof)
					state_next = onehot(s_id_a);
			state[s_id_a]:
			begin
				field_sel = field_id_a;
				if (bit_ok && bit_count == 7'(LEN_ID_A - 1))
					state_next = onehot(s_rtr_srr);
			end
			state[s_rtr_srr]:
			begin
				field_sel = field_rtr_srr;
				if (bit_ok)
					state_next = onehot(s_ide);
			end
			state[s_ide]:
			begin
				field_sel = field_ide;
				if (bit_ok)
					state_next = rx_bit ? onehot(s_id_b) : onehot(s_reserved0);  // Extended or base
			end
			state[s_id_b]:
			begin
				field_sel = field_id_b;
				if (bit_ok && bit_count == 7'(LEN_ID_B - 1))
					state_next = onehot(s_rtr);
			end
			state[s_rtr]:
			begin
				field_sel = field_rtr;
				if (bit_ok)
					state_next = onehot(s_reserved1);
			end
			state[s_reserved1]:
			begin
				field_sel = field_reserved1;
				if (bit_ok)
					state_next = onehot(s_reserved0);
			end
			state[s_reserved0]:
			begin
				field_sel = field_reserved0;
				if (bit_ok)
					state_next = onehot(s_dlc);
			end
			state[s_dlc]:
			begin
				field_sel = field_dlc;
				// Last DLC bit not yet in frame.dlc, the first three are
				if (bit_ok && bit_count == 7'(LEN_DLC - 1))
				begin
					if (frame.rtr || {frame.dlc[2:0], rx_bit} == '0)
						state_next = onehot(s_crc);   // Remote frame or no data
					else
						state_next = onehot(s_data);
				end
			end
			state[s_data]:
			begin
				field_sel = field_data;
				if (bit_ok && bit_count == data_len - 7'd1)
					state_next = onehot(s_crc);
			end
			state[s_crc]:
			begin
				field_sel = field_crc;
				if (bit_ok && bit_count == 7'(LEN_CRC - 1))
					state_next = onehot(s_crc_delimiter);
			end
			state[s_crc_delimiter]:
				if (bit_ok)
				begin
					if (!rx_bit)
						kind = error_crc_delimiter;
					else
						state_next = onehot(s_ack_slot);
				end
			state[s_ack_slot]:
				if (sample_point)
				begin
					if (rx_bit)
						kind = error_ack_slot;   // Nobody acknowledged
					else
						state_next = onehot(s_ack_delimiter);
				end
			state[s_ack_delimiter]:
				if (sample_point)
				begin
					if (crc_value != frame.crc)
						kind = error_crc_mismatch;
					else if (!rx_bit)
						kind = error_ack_delimiter;
					else
						state_next = onehot(s_eof);
				end
			state[s_eof]:
				if (sample_point)
				begin
					if (!rx_bit)
						kind = error_eof;
					else if (bit_count == 7'(LEN_EOF - 1))
					begin
						state_next = onehot(s_intermission);
						done = 1'b1;
					end
				end
			state[s_intermission]:
				if (sof)
					state_next = onehot(s_id_a);   // Back-to-back frame
				else if (sample_point && bit_count == 7'(LEN_INTERMISSION - 1))
					state_next = onehot(s_idle);
			state[s_error_flags]:
				if (sample_point)
				begin
					if (rx_bit)
					begin
						// First recessive bit already belongs to the delimiter
						if (bit_count >= 7'(LEN_FLAGS_MIN))
							state_next = onehot(s_error_delimiter);
						else
							kind = error_flag_length;
					end
					else if (bit_count >= 7'(LEN_FLAGS_MAX))
						kind = error_flag_length;
				end
			state[s_error_delimiter]:
				if (sample_point && bit_count == 7'(LEN_DELIMITER - 2))
					state_next = onehot(s_intermission);
			default:
				state_next = onehot(s_idle);   // Lost one-hot
		endcase

		if (stuff_error)
			kind = error_stuff;   // Overrides any field error
		if (kind != error_none)
			state_next = onehot(s_error_flags);
	end

	//======================================================================
	// State, counter and registered outputs
	//======================================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= onehot(s_idle);
			bit_count <= '0;
			frame_done <= 1'b0;
			error_detected <= 1'b0;
			error_kind <= error_none;
		end
		else
		begin
			state <= state_next;
			if (bit_ok)
			begin
				// Restart on a new field or on a repeated error flag
				if (state_next != state || kind != error_none)
					bit_count <= '0;
				else
					bit_count <= bit_count + 7'd1;
			end
			frame_done <= done;
			error_detected <= (kind != error_none);
			error_kind <= kind;   // None outside the pulse
		end
	end

endmodule

`default_nettype wire

//--- hw/can_field_regs.sv
`timescale 1ns/10ps
`default_nettype none

module can_field_regs
	import can_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire can_capture_t capture,   // One destuffed bit per strobe
	output can_frame_t frame
);

	logic rtr_srr_hold;   // Meaning known only once IDE is seen
	logic value;

	assign value = capture.bit_value;

	//======================================================================
	// Field shift registers
	//======================================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			frame <= '0;
			rtr_srr_hold <= 1'b0;
		end
		else if (capture.strobe)
		begin
			unique case (capture.field)
				field_id_a:
					frame.id_a <= {frame.id_a[LEN_ID_A-2:0], value};   // MSB first
				field_rtr_srr:
					rtr_srr_hold <= value;
				field_ide:
				begin
					frame.ide <= value;
					if (value)
						frame.srr <= rtr_srr_hold;   // Extended frame
				end
				field_id_b:
					frame.id_b <= {frame.id_b[LEN_ID_B-2:0], value};
				field_rtr:
					frame.rtr <= value;   // Extended frame RTR
				field_reserved1:
					frame.reserved1 <= value;
				field_reserved0:
				begin
					frame.reserved0 <= value;
					if (!frame.ide)
						frame.rtr <= rtr_srr_hold;   // Base frame RTR
					// Fresh DLC and data for this frame
					frame.dlc <= '0;
					frame.data <= '0;
				end
				field_dlc:
				begin
					// Bit 2 set only on the last shift since DLC starts cleared
					if (frame.dlc[2])
						frame.dlc <= LEN_DLC'(MAX_DLC);   // Codes 8..15
					else
						frame.dlc <= {frame.dlc[LEN_DLC-2:0], value};
				end
				field_data:
					frame.data <= {frame.data[8*MAX_DLC-2:0], value};   // Right-aligned
				field_crc:
					frame.crc <= {frame.crc[LEN_CRC-2:0], value};
				default:
					rtr_srr_hold <= rtr_srr_hold;   // No field
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/can_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module can_decoder
	import can_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire rx_bit,          // Bus level, 0 is dominant
	input wire sample_point,    // One cycle per bit time
	output can_frame_t frame,
	output logic frame_done,
	output logic error_detected,
	output can_error_e error_kind
);

	logic stuff_bit;
	logic stuff_error;
	logic stuff_active;
	logic crc_shift;
	logic crc_clear;
	logic [LEN_CRC-1:0] crc_value;
	can_capture_t capture;

	//======================================================================
	// Bit level
	//======================================================================

	can_bit_stuff can_bit_stuff_inst (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.stuff_active(stuff_active),
		.stuff_bit(stuff_bit),
		.stuff_error(stuff_error)
	);

	can_crc15 can_crc15_inst (
		.clock(clock),
		.reset(reset),
		.crc_clear(crc_clear),
		.crc_shift(crc_shift),
		.rx_bit(rx_bit),
		.crc_value(crc_value)
	);

	//======================================================================
	// Frame level
	//======================================================================

	can_frame_sequencer can_frame_sequencer_inst (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.stuff_bit(stuff_bit),
		.stuff_error(stuff_error),
		.crc_value(crc_value),
		.frame(frame),
		.stuff_active(stuff_active),
		.crc_shift(crc_shift),
		.crc_clear(crc_clear),
		.capture(capture),
		.frame_done(frame_done),
		.error_detected(error_detected),
		.error_kind(error_kind)
	);

	can_field_regs can_field_regs_inst (
		.clock(clock),
		.reset(reset),
		.capture(capture),
		.frame(frame)
	);

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
(
	output logic clock,
	output logic reset
);

	localparam int HALF_PERIOD = 20;   // 40 ns clock
	localparam int RESET_CYCLES = 10;

	initial
	begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	// Release away from the active edge
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- verification/tb_can_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module tb_can_decoder
	import can_pkg::*;
();

	localparam logic [1:0] NO_CORRUPT = 2'd0;
	localparam logic [1:0] FLIP_STUFF = 2'd1;
	localparam logic [1:0] FLIP_CRC = 2'd2;
	localparam logic [1:0] EOF_DOMINANT = 2'd3;
	localparam int NUM_TESTS = 16;
	localparam int IDLE_BITS = 4;    // Between frames

	typedef struct packed {
		logic [8*12-1:0] name;
		logic [28:0] id;             // Base frames use the low 11 bits
		logic ide;
		logic rtr;
		logic [3:0] dlc;
		logic ack;                   // 0 is an acknowledged frame
		logic [1:0] corrupt;
		can_error_e expect_error;
	} test_t;

	logic clock;
	logic reset;
	logic rx_bit;
	logic sample_point;
	can_frame_t frame;
	logic frame_done;
	logic error_detected;
	can_error_e error_kind;

	test_t tests [NUM_TESTS];
	bit raw [$];                     // Unstuffed SOF through CRC
	bit stream [$];                  // Bits as they go on the bus
	logic [14:0] crc_ref;
	can_frame_t expect_frame;
	int done_count;
	int error_count_dut;
	can_error_e seen_kind;

	tb_clock_gen tb_clock_gen_inst (.clock(clock), .reset(reset));

	can_decoder can_decoder_inst (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.frame(frame),
		.frame_done(frame_done),
		.error_detected(error_detected),
		.error_kind(error_kind)
	);

	// Pulse monitor on the falling edge
	always @(negedge clock)
	begin
		if (frame_done)
			done_count++;
		if (error_detected)
		begin
			error_count_dut++;
			seen_kind = error_kind;
		end
	end

	//======================================================================
	// Stimulus helpers
	//======================================================================

	// CAN CRC-15 with generator 0x4599
	task automatic push_raw(input bit b);
		logic nxt;
		raw.push_back(b);
		nxt = b ^ crc_ref[14];
		crc_ref = {crc_ref[13:0], 1'b0};
		if (nxt)
			crc_ref = crc_ref ^ 15'h4599;
	endtask

	task automatic push_field(input logic [28:0] value, input int width);
		for (int i = width - 1; i >= 0; i--)
			push_raw(value[i]);   // MSB first
	endtask

	// Opposite bit after five equal ones and at the CRC end too
	task automatic stuff_bits(output int first_stuff);
		int run;
		bit last;
		run = 0;
		last = 1'b1;
		first_stuff = -1;
		stream.delete();
		foreach (raw[i])
		begin
			stream.push_back(raw[i]);
			run = (raw[i] == last) ? run + 1 : 1;
			last = raw[i];
			if (run == 5)
			begin
				if (first_stuff < 0)
					first_stuff = stream.size();
				stream.push_back(~last);
				last = ~last;
				run = 1;
			end
		end
	endtask

	task automatic send_bit(input bit b);
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clock);
			if (i == 0)
				rx_bit = b;
			sample_point = (i == 1);   // Every fourth clock
		end
	endtask

	//======================================================================
	// Checks
	//======================================================================

	task automatic check_frame(input logic [8*12-1:0] name, input can_frame_t exp,
		input can_frame_t act);
		if (exp !== act)
		begin
			$display("error: %s expected %h actual %h", name, exp, act);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_error(input logic [8*12-1:0] name, input can_error_e exp,
		input can_error_e act);
		if (exp !== act)
		begin
			$display("error: %s expected %s actual %s", name, exp.name(), act.name());
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	// One frame_done for a good frame or one error_detected for a bad one
	task automatic verify_pulse_counts(input logic [8*12-1:0] name, input int exp_errors,
		input int dones, input int errs);
		if (dones != 1 - exp_errors || errs != exp_errors)
		begin
			$display("error: %s expected %0d frame_done %0d error_detected actual %0d %0d",
				name, 1 - exp_errors, exp_errors, dones, errs);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	//======================================================================
	// Main sequence
	//======================================================================

	initial
	begin
		int first_stuff;
		int cut;
		int nbytes;
		int done_start;
		int error_start;
		int expect_errors;
		int total_bits;
		int limit_ns;
		logic [63:0] data;
		logic [14:0] crc_sent;

		rx_bit = 1'b1;
		sample_point = 1'b0;
		done_count = 0;
		error_count_dut = 0;
		seen_kind = error_none;
		expect_frame = '0;
		void'($urandom(32'hae00_c06b));

		tests[0] = '{"base_dlc0", 29'h123, 0, 0, 4'd0, 0, NO_CORRUPT, error_none};
		tests[1] = '{"base_dlc1", 29'h7ff, 0, 0, 4'd1, 0, NO_CORRUPT, error_none};
		tests[2] = '{"base_dlc4", 29'h555, 0, 0, 4'd4, 0, NO_CORRUPT, error_none};
		tests[3] = '{"base_dlc8", 29'h2a1, 0, 0, 4'd8, 0, NO_CORRUPT, error_none};
		tests[4] = '{"ext_data", 29'h1abc_def1, 1, 0, 4'd5, 0, NO_CORRUPT, error_none};
		tests[5] = '{"ext_remote", 29'h0f0f_0f0f, 1, 1, 4'd3, 0, NO_CORRUPT, error_none};
		tests[6] = '{"base_remote", 29'h3c3, 0, 1, 4'd2, 0, NO_CORRUPT, error_none};
		tests[7] = '{"dlc_clamp9", 29'h100, 0, 0, 4'd9, 0, NO_CORRUPT, error_none};
		tests[8] = '{"dlc_clamp15", 29'h1fff_ffff, 1, 0, 4'd15, 0, NO_CORRUPT, error_none};
		tests[9] = '{"long_runs", 29'h000, 0, 0, 4'd2, 0, NO_CORRUPT, error_none};
		tests[10] = '{"flip_stuff", 29'h000, 0, 0, 4'd0, 0, FLIP_STUFF, error_stuff};
		tests[11] = '{"after_stuff", 29'h4a5, 0, 0, 4'd3, 0, NO_CORRUPT, error_none};
		tests[12] = '{"flip_crc", 29'h321, 0, 0, 4'd2, 0, FLIP_CRC, error_crc_mismatch};
		tests[13] = '{"no_ack", 29'h654, 0, 0, 4'd1, 1, NO_CORRUPT, error_ack_slot};
		tests[14] = '{"eof_dominant", 29'h0aa, 0, 0, 4'd1, 0, EOF_DOMINANT, error_eof};
		tests[15] = '{"recover", 29'h0123_4567, 1, 0, 4'd6, 0, NO_CORRUPT, error_none};

		// Worst-case bus bits per test with stuffing
		total_bits = IDLE_BITS;
		foreach (tests[i])
		begin
			nbytes = tests[i].rtr ? 0 : ((tests[i].dlc > 8) ? 8 : tests[i].dlc);
			total_bits += (34 + (tests[i].ide ? 20 : 0) + 8 * nbytes) * 6 / 5 + 1;
			total_bits += 12 + 16 + IDLE_BITS;
		end
		limit_ns = total_bits * 4 * 40 * 12 / 10 + 10 * 40;
		fork
			begin
				#(limit_ns);
				$display("Timeout: the tests did not finish within %0d ns", limit_ns);
				$display("Simulation FAILED");
				$fatal(1);
			end
		join_none

		wait (!reset);
		repeat (IDLE_BITS) send_bit(1'b1);

		foreach (tests[t])
		begin
			nbytes = tests[t].rtr ? 0 : ((tests[t].dlc > 8) ? 8 : tests[t].dlc);
			data = '0;
			for (int b = 0; b < nbytes; b++)
				data = {data[55:0], 8'($urandom)};

			raw.delete();
			crc_ref = '0;
			push_raw(1'b0);   // SOF
			if (tests[t].ide)
			begin
				push_field(29'(tests[t].id[28:18]), 11);
				push_raw(1'b1);   // SRR
				push_raw(1'b1);   // IDE
				push_field(29'(tests[t].id[17:0]), 18);
				push_raw(tests[t].rtr);
				push_raw(1'b0);   // r1
			end
			else
			begin
				push_field(29'(tests[t].id[10:0]), 11);
				push_raw(tests[t].rtr);
				push_raw(1'b0);   // IDE
			end
			push_raw(1'b0);   // r0
			push_field(29'(tests[t].dlc), 4);
			for (int b = nbytes - 1; b >= 0; b--)
				push_field(29'(data[8*b +: 8]), 8);
			crc_sent = crc_ref;   // Register runs on through the CRC bits
			if (tests[t].corrupt == FLIP_CRC)
				crc_sent[3] = ~crc_sent[3];
			push_field(29'(crc_sent), 15);
			stuff_bits(first_stuff);

			cut = -1;
			if (tests[t].corrupt == FLIP_STUFF)
			begin
				stream[first_stuff] = ~stream[first_stuff];
				cut = first_stuff;
			end
			stream.push_back(1'b1);   // CRC delimiter
			stream.push_back(tests[t].ack);
			if (tests[t].ack)
				cut = stream.size() - 1;
			stream.push_back(1'b1);   // ACK delimiter
			if (tests[t].corrupt == FLIP_CRC)
				cut = stream.size() - 1;
			for (int e = 0; e < 7; e++)
				stream.push_back(!(tests[t].corrupt == EOF_DOMINANT && e == 3));
			if (tests[t].corrupt == EOF_DOMINANT)
				cut = stream.size() - 4;
			if (cut >= 0)
			begin
				stream = stream[0:cut];
				repeat (6) stream.push_back(1'b0);   // Error flag
				repeat (8) stream.push_back(1'b1);   // Error delimiter
			end
			repeat (2 + IDLE_BITS) stream.push_back(1'b1);   // Intermission and idle

			expect_errors = (tests[t].expect_error != error_none) ? 1 : 0;
			done_start = done_count;
			error_start = error_count_dut;
			seen_kind = error_none;
			foreach (stream[i])
				send_bit(stream[i]);

			verify_pulse_counts(tests[t].name, expect_errors, done_count - done_start,
				error_count_dut - error_start);
			if (tests[t].expect_error != error_none)
				check_error(tests[t].name, tests[t].expect_error, seen_kind);
			else
			begin
				// Fields not sent in this frame keep their old value
				expect_frame.ide = tests[t].ide;
				expect_frame.rtr = tests[t].rtr;
				expect_frame.reserved0 = 1'b0;
				expect_frame.dlc = 4'(nbytes == 8 || tests[t].dlc > 8 ? 8 : tests[t].dlc);
				expect_frame.data = data;
				expect_frame.crc = crc_sent;
				if (tests[t].ide)
				begin
					expect_frame.id_a = tests[t].id[28:18];
					expect_frame.id_b = tests[t].id[17:0];
					expect_frame.srr = 1'b1;
					expect_frame.reserved1 = 1'b0;
				end
				else
					expect_frame.id_a = tests[t].id[10:0];
				check_frame(tests[t].name, expect_frame, frame);
			end
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
hw/can_pkg.sv
hw/can_bit_stuff.sv
hw/can_crc15.sv
hw/can_frame_sequencer.sv
hw/can_field_regs.sv
hw/can_decoder.sv
verification/tb_clock_gen.sv
verification/tb_can_decoder.sv

//--- run.sh
#!/bin/bash
# Build and run the CAN decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
( verilator --binary --timing -f list.f --top-module tb_can_decoder -o tb_sim \
	&& ./obj_dir/tb_sim ) > sim.log 2>&1 || true

grep -q "^Simulation PASSED$" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }
